// File: project.f
source/dsp_link_pkg.sv
source/mcbsp_rx_deser.sv
source/dsp_cmd_decoder.sv
source/sync_pos_capture.sv
source/payload_pingpong_buf.sv
source/dsp_fpga_link.sv
testbench/dsp_fpga_link_properties.sv
testbench/dsp_fpga_link_tb.sv

// File: source/dsp_cmd_decoder.sv
module dsp_cmd_decoder (
  input  logic                             mcbsp0_slaver_clkx,
  input  logic                             cfg_rst,
  input  dsp_link_pkg::dsp_word_u          rx_word,
  input  logic                             rx_valid,
  output logic                             send_start,
  output logic                             start_send,
  output logic [dsp_link_pkg::step_w-1:0]  send_step,
  output logic                             part_syn_start,
  output logic                             lose,
  output logic                             flag_coarse,
  output logic                             flag_fine,
  output logic                             coarse_data_flag,
  output logic                             fine_data_flag,
  output logic                             decode_data_flag,
  output logic                             tx_data_flag,
  output logic                             dsp_start_send,
  output logic                             coarse_arm,
  output logic                             fine_arm,
  output logic                             payload_arm
);

  import dsp_link_pkg::*;

  logic       step_hit;
  logic [2:0] step_num;
  logic       is_part_syn;
  logic       send_start_d;  // widens start_send to two cycles

  // AAAAnnnn with all nibbles equal and n below 8
  assign step_hit = (rx_word.cmd.tag == cmd_step_tag) && !rx_word.cmd.arg[3] &&
                    (rx_word.cmd.arg == {4{rx_word.cmd.arg[3:0]}});
  assign step_num    = rx_word.cmd.arg[2:0];
  assign is_part_syn = (rx_word.raw == cmd_part_syn);

  assign start_send  = send_start || send_start_d;
  assign coarse_arm  = flag_coarse;   // capture takes the next word
  assign fine_arm    = flag_fine;
  assign payload_arm = tx_data_flag;  // block of payload follows

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      send_start       <= 1'b0;
      send_start_d     <= 1'b0;
      send_step        <= '0;
      part_syn_start   <= 1'b0;
      lose             <= 1'b0;
      flag_coarse      <= 1'b0;
      flag_fine        <= 1'b0;
      coarse_data_flag <= 1'b0;
      fine_data_flag   <= 1'b0;
      decode_data_flag <= 1'b0;
      tx_data_flag     <= 1'b0;
      dsp_start_send   <= 1'b0;
    end else begin
      send_start_d     <= send_start;
      send_start       <= rx_valid && (step_hit || is_part_syn ||
                                       rx_word.raw == cmd_fine_data ||
                                       rx_word.raw == cmd_decode_data);
      part_syn_start   <= rx_valid && is_part_syn;
      coarse_data_flag <= rx_valid && is_part_syn;
      lose             <= rx_valid && (rx_word.raw == cmd_lose);
      flag_coarse      <= rx_valid && (rx_word.raw == cmd_coarse_syn);
      flag_fine        <= rx_valid && (rx_word.raw == cmd_fine_syn);
      fine_data_flag   <= rx_valid && (rx_word.raw == cmd_fine_data);
      decode_data_flag <= rx_valid && (rx_word.raw == cmd_decode_data);
      tx_data_flag     <= rx_valid && (rx_word.raw == cmd_tx_start);
      if (rx_valid && rx_word.raw == cmd_tx_start)
        dsp_start_send <= 1'b1;  // sticky
      if (rx_valid && step_hit)
        send_step <= step_w'(step_num);
      else if (rx_valid && is_part_syn)
        send_step <= '0;  // part sync restarts at step 0
    end
  end

endmodule

// File: source/dsp_fpga_link.sv
module dsp_fpga_link #(
  parameter int unsigned payload_words = 40,
  parameter int unsigned bank_aw       = 6
) (
  input  logic                             mcbsp0_slaver_clkx,
  input  logic                             cfg_rst,
  input  logic                             mcbsp0_slaver_fsx,
  input  logic                             mcbsp0_slaver_mosi,
  // buffer read port
  input  logic [bank_aw:0]                 read_addr,
  input  logic                             rd_req,
  output logic                             rd_ack,
  output logic [dsp_link_pkg::word_w-1:0]  send_data,
  // decoder
  output logic                             send_start,
  output logic                             start_send,
  output logic [dsp_link_pkg::step_w-1:0]  send_step,
  output logic                             part_syn_start,
  output logic                             lose,
  output logic                             flag_coarse,
  output logic                             flag_fine,
  output logic                             coarse_data_flag,
  output logic                             fine_data_flag,
  output logic                             decode_data_flag,
  output logic                             tx_data_flag,
  output logic                             dsp_start_send,
  // sync capture
  output logic [dsp_link_pkg::word_w-1:0]  coarse_syn_pos,
  output logic [dsp_link_pkg::word_w-1:0]  fine_syn_pos,
  output logic                             coarse_end,
  output logic                             fine_end,
  // payload
  output logic                             tx_send_start
);

  import dsp_link_pkg::*;

  dsp_word_u rx_word;
  logic      rx_valid;
  logic      coarse_arm;
  logic      fine_arm;
  logic      payload_arm;

  mcbsp_rx_deser mcbsp_rx_deser_i (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .mcbsp0_slaver_fsx  (mcbsp0_slaver_fsx),
    .mcbsp0_slaver_mosi (mcbsp0_slaver_mosi),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid)
  );

  dsp_cmd_decoder dsp_cmd_decoder_i (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .send_start         (send_start),
    .start_send         (start_send),
    .send_step          (send_step),
    .part_syn_start     (part_syn_start),
    .lose               (lose),
    .flag_coarse        (flag_coarse),
    .flag_fine          (flag_fine),
    .coarse_data_flag   (coarse_data_flag),
    .fine_data_flag     (fine_data_flag),
    .decode_data_flag   (decode_data_flag),
    .tx_data_flag       (tx_data_flag),
    .dsp_start_send     (dsp_start_send),
    .coarse_arm         (coarse_arm),
    .fine_arm           (fine_arm),
    .payload_arm        (payload_arm)
  );

  sync_pos_capture sync_pos_capture_i (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .coarse_arm         (coarse_arm),
    .fine_arm           (fine_arm),
    .coarse_syn_pos     (coarse_syn_pos),
    .fine_syn_pos       (fine_syn_pos),
    .coarse_end         (coarse_end),
    .fine_end           (fine_end)
  );

  payload_pingpong_buf #(
    .payload_words (payload_words),
    .bank_aw       (bank_aw)
  ) payload_pingpong_buf_i (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .payload_arm        (payload_arm),
    .tx_send_start      (tx_send_start),
    .read_addr          (read_addr),
    .rd_req             (rd_req),
    .rd_ack             (rd_ack),
    .send_data          (send_data)
  );

endmodule

// File: source/dsp_link_pkg.sv
package dsp_link_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int word_w = 32;  // one mcbsp word
  localparam int step_w = 17;  // send step number

  // a received word, seen as a command or as raw data
  typedef union packed {
    logic [word_w-1:0] raw;
    struct packed {
      logic [15:0] tag;  // upper half
      logic [15:0] arg;  // lower half
    } cmd;
  } dsp_word_u;

  ////////////////////////////////////////
  // dsp command codes
  ////////////////////////////////////////

  // step codes are AAAAnnnn, n = 0..7
  localparam logic [15:0] cmd_step_tag = 16'hAAAA;

  localparam logic [word_w-1:0] cmd_part_syn    = 32'hAAAA_AAAA;  // part sync start
  localparam logic [word_w-1:0] cmd_fine_data   = 32'h6666_6666;
  localparam logic [word_w-1:0] cmd_decode_data = 32'h5555_5555;
  localparam logic [word_w-1:0] cmd_lose        = 32'h1111_1111;
  localparam logic [word_w-1:0] cmd_coarse_syn  = 32'h4444_4444;
  localparam logic [word_w-1:0] cmd_fine_syn    = 32'h3333_3333;
  localparam logic [word_w-1:0] cmd_tx_start    = 32'h6666_9999;  // payload block follows

endpackage

// File: source/mcbsp_rx_deser.sv
module mcbsp_rx_deser (
  input  logic                   mcbsp0_slaver_clkx,
  input  logic                   cfg_rst,
  input  logic                   mcbsp0_slaver_fsx,
  input  logic                   mcbsp0_slaver_mosi,
  output dsp_link_pkg::dsp_word_u rx_word,
  output logic                   rx_valid
);

  import dsp_link_pkg::*;

  localparam int cnt_w = $clog2(word_w);

  logic             busy;     // inside a frame
  logic [cnt_w-1:0] bit_cnt;  // bits taken so far
  logic [word_w-1:0] shift_q;
  logic             last_bit;

  assign last_bit = busy && (bit_cnt == cnt_w'(word_w - 1));

  // frame control
  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      busy     <= 1'b0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= last_bit;
      if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (last_bit)
          busy <= 1'b0;
      end
      // fsx may come with bit 0 of the previous word
      if (mcbsp0_slaver_fsx) begin
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
    end
  end

  // msb first
  always_ff @(posedge mcbsp0_slaver_clkx) begin
    if (busy)
      shift_q <= {shift_q[word_w-2:0], mcbsp0_slaver_mosi};
    if (last_bit)
      rx_word.raw <= {shift_q[word_w-2:0], mcbsp0_slaver_mosi};  // complete word at E
  end

endmodule

// File: source/payload_pingpong_buf.sv
module payload_pingpong_buf #(
  parameter int unsigned payload_words = 40,
  parameter int unsigned bank_aw       = 6
) (
  input  logic                             mcbsp0_slaver_clkx,
  input  logic                             cfg_rst,
  input  dsp_link_pkg::dsp_word_u          rx_word,
  input  logic                             rx_valid,
  input  logic                             payload_arm,
  output logic                             tx_send_start,
  input  logic [bank_aw:0]                 read_addr,
  input  logic                             rd_req,
  output logic                             rd_ack,
  output logic [dsp_link_pkg::word_w-1:0]  send_data
);

  import dsp_link_pkg::*;

  localparam int unsigned depth = 2 ** (bank_aw + 1);

  logic               wr_en;   // block in progress
  logic [bank_aw-1:0] wr_idx;  // index within the bank
  logic               bank;    // bank being filled
  logic               wr_fire;
  logic               wr_last;
  logic               rd_take;

  logic [word_w-1:0] mem [depth];

  assign wr_fire = wr_en && rx_valid;
  assign wr_last = (wr_idx == bank_aw'(payload_words - 1));
  assign rd_take = rd_req && !rd_ack;  // new request seen

  ////////////////////////////////////////
  // write sequencer
  ////////////////////////////////////////

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      wr_en         <= 1'b0;
      wr_idx        <= '0;
      bank          <= 1'b0;
      tx_send_start <= 1'b0;
    end else begin
      tx_send_start <= 1'b0;
      if (wr_fire) begin
        if (wr_last) begin
          wr_idx        <= '0;
          bank          <= ~bank;  // ping-pong
          wr_en         <= 1'b0;
          tx_send_start <= 1'b1;   // block complete
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end else if (payload_arm) begin
        wr_en <= 1'b1;
      end
    end
  end

  // command words inside a block land here as data too
  always_ff @(posedge mcbsp0_slaver_clkx) begin
    if (wr_fire)
      mem[{bank, wr_idx}] <= rx_word.raw;
  end

  ////////////////////////////////////////
  // read port, four-phase req/ack
  ////////////////////////////////////////

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      rd_ack <= 1'b0;
    end else if (rd_take) begin
      rd_ack <= 1'b1;
    end else if (!rd_req) begin
      rd_ack <= 1'b0;  // host released req
    end
  end

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst)
      send_data <= '0;
    else if (rd_take)
      send_data <= mem[read_addr];  // held until next ack
  end

endmodule

// File: source/sync_pos_capture.sv
module sync_pos_capture (
  input  logic                             mcbsp0_slaver_clkx,
  input  logic                             cfg_rst,
  input  dsp_link_pkg::dsp_word_u          rx_word,
  input  logic                             rx_valid,
  input  logic                             coarse_arm,
  input  logic                             fine_arm,
  output logic [dsp_link_pkg::word_w-1:0]  coarse_syn_pos,
  output logic [dsp_link_pkg::word_w-1:0]  fine_syn_pos,
  output logic                             coarse_end,
  output logic                             fine_end
);

  import dsp_link_pkg::*;

  // channel 0 is coarse, channel 1 is fine
  logic [1:0]        arm;
  logic [1:0]        armed;
  logic [1:0]        done;
  logic [word_w-1:0] pos [2];

  assign arm = {fine_arm, coarse_arm};

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      armed <= '0;
      done  <= '0;
      pos   <= '{default: '0};
    end else begin
      for (int i = 0; i < 2; i++) begin
        done[i] <= 1'b0;
        if (armed[i] && rx_valid) begin
          pos[i]   <= rx_word.raw;  // the word right after the sync command
          done[i]  <= 1'b1;
          armed[i] <= 1'b0;
        end else if (arm[i]) begin
          armed[i] <= 1'b1;
        end
      end
    end
  end

  assign coarse_syn_pos = pos[0];
  assign fine_syn_pos   = pos[1];
  assign coarse_end     = done[0];
  assign fine_end       = done[1];

endmodule

// File: testbench/dsp_fpga_link_properties.sv
module dsp_fpga_link_properties (
  input logic mcbsp0_slaver_clkx,
  input logic cfg_rst,
  input logic rd_req,
  input logic rd_ack,
  input logic send_start,
  input logic start_send,
  input logic coarse_end,
  input logic tx_send_start
);

  timeunit 1ns;
  timeprecision 1ps;

  logic failed = 1'b0;  // set by any failing assertion

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    $rose(rd_ack) |-> $past(rd_req))
    else begin
      $error("rd_ack rose without rd_req");
      failed = 1'b1;
    end

  send_start_pulse: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    send_start |=> !send_start)
    else begin
      $error("send_start wider than one cycle");
      failed = 1'b1;
    end

  coarse_end_pulse: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    coarse_end |=> !coarse_end)
    else begin
      $error("coarse_end wider than one cycle");
      failed = 1'b1;
    end

  tx_done_pulse: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    tx_send_start |=> !tx_send_start)
    else begin
      $error("tx_send_start wider than one cycle");
      failed = 1'b1;
    end

  // two cycles of start_send per send_start
  start_send_follows: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    send_start |=> start_send ##1 !start_send)
    else begin
      $error("start_send does not follow");
      failed = 1'b1;
    end

endmodule

// File: testbench/dsp_fpga_link_tb.sv
module dsp_fpga_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int period          = 10;
  localparam int payload_words   = 40;
  localparam int bank_aw         = 6;
  localparam int tbl_len         = 102;  // 8 steps, 5 commands, 6 sync, 2 blocks of 41, 1 step
  localparam int watchdog_cycles = tbl_len * 40 + 3 * payload_words * 8 + 100;
  localparam logic [15:0] lfsr_seed = 16'd10412;

  // pulse_vec bit masks
  localparam logic [11:0] p_send   = 12'h800;
  localparam logic [11:0] p_part   = 12'h400;
  localparam logic [11:0] p_lose   = 12'h200;
  localparam logic [11:0] p_fcoar  = 12'h100;
  localparam logic [11:0] p_ffine  = 12'h080;
  localparam logic [11:0] p_cdata  = 12'h040;
  localparam logic [11:0] p_fdata  = 12'h020;
  localparam logic [11:0] p_ddata  = 12'h010;
  localparam logic [11:0] p_txdata = 12'h008;
  localparam logic [11:0] p_cend   = 12'h004;
  localparam logic [11:0] p_fend   = 12'h002;
  localparam logic [11:0] p_txdone = 12'h001;

  typedef struct {
    logic [31:0] word;
    logic [11:0] pulses;
    logic [16:0] step;
    logic [31:0] cpos;
    logic [31:0] fpos;
    logic        started;  // dsp_start_send level
  } entry_t;

  logic mcbsp0_slaver_clkx = 1'b0;
  logic cfg_rst;
  logic mcbsp0_slaver_fsx;
  logic mcbsp0_slaver_mosi;
  logic [bank_aw:0] read_addr;
  logic rd_req;
  logic rd_ack;
  logic [31:0] send_data;
  logic send_start, start_send, part_syn_start, lose, flag_coarse, flag_fine;
  logic coarse_data_flag, fine_data_flag, decode_data_flag, tx_data_flag, dsp_start_send;
  logic coarse_end, fine_end, tx_send_start;
  logic [16:0] send_step;
  logic [31:0] coarse_syn_pos, fine_syn_pos;
  logic [11:0] pulse_vec;

  entry_t      tbl [tbl_len];
  logic [31:0] exp_mem [2 ** (bank_aw + 1)];
  logic [15:0] lfsr_q = lfsr_seed;
  int          n_ent;
  logic [16:0] cur_step;
  logic [31:0] cur_cpos, cur_fpos;
  logic        cur_started;
  int          blocks_done;

  assign pulse_vec = {send_start, part_syn_start, lose, flag_coarse, flag_fine,
                      coarse_data_flag, fine_data_flag, decode_data_flag, tx_data_flag,
                      coarse_end, fine_end, tx_send_start};

  always #(period / 2) mcbsp0_slaver_clkx = ~mcbsp0_slaver_clkx;

  dsp_fpga_link #(
    .payload_words (payload_words),
    .bank_aw       (bank_aw)
  ) dsp_fpga_link_i (.*);

  bind dsp_fpga_link dsp_fpga_link_properties dsp_fpga_link_properties_i (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rd_req             (rd_req),
    .rd_ack             (rd_ack),
    .send_start         (send_start),
    .start_send         (start_send),
    .coarse_end         (coarse_end),
    .tx_send_start      (tx_send_start)
  );

  ////////////////////////////////////////
  // random words
  ////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      w = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic logic is_cmd(logic [31:0] w);
    return (w[31:16] == 16'hAAAA) || (w == 32'h6666_6666) || (w == 32'h5555_5555) ||
           (w == 32'h1111_1111) || (w == 32'h4444_4444) || (w == 32'h3333_3333) ||
           (w == 32'h6666_9999);
  endfunction

  function automatic logic [31:0] rand_data();
    logic [31:0] w;
    do
      w = rand_word();
    while (is_cmd(w));  // keep random words silent to the decoder
    return w;
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic add_entry(input logic [31:0] w, input logic [11:0] p);
    tbl[n_ent] = '{w, p, cur_step, cur_cpos, cur_fpos, cur_started};
    n_ent++;
  endtask

  task automatic build_table();
    logic [31:0] w;
    logic [3:0]  nib;
    n_ent = 0;
    cur_step = '0;
    cur_cpos = '0;
    cur_fpos = '0;
    cur_started = 1'b0;
    for (int s = 0; s < 8; s++) begin
      nib = 4'(s);
      cur_step = 17'(s);
      add_entry({16'hAAAA, {4{nib}}}, p_send);
    end
    add_entry(32'h1111_1111, p_lose);  // step holds at 7
    add_entry(rand_data(), '0);
    add_entry(32'h6666_6666, p_send | p_fdata);
    add_entry(32'h5555_5555, p_send | p_ddata);
    cur_step = '0;
    add_entry(32'hAAAA_AAAA, p_send | p_part | p_cdata);
    add_entry(32'h4444_4444, p_fcoar);
    w = rand_data();
    cur_cpos = w;
    add_entry(w, p_cend);
    add_entry(rand_data(), '0);  // capture already done
    add_entry(32'h3333_3333, p_ffine);
    w = rand_data();
    cur_fpos = w;
    add_entry(w, p_fend);
    add_entry(rand_data(), '0);
    cur_started = 1'b1;
    for (int b = 0; b < 2; b++) begin
      add_entry(32'h6666_9999, p_txdata);
      for (int i = 0; i < payload_words; i++) begin
        w = rand_data();
        exp_mem[b * (2 ** bank_aw) + i] = w;
        add_entry(w, (i == payload_words - 1) ? p_txdone : 12'h000);
      end
    end
    cur_step = 17'd5;
    add_entry(32'hAAAA_5555, p_send);  // nonzero step ahead of the second reset
  endtask

  ////////////////////////////////////////
  // drivers and checks
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // frame sync one bit ahead, then msb first
  task automatic send_word(input logic [31:0] w);
    @(negedge mcbsp0_slaver_clkx);
    mcbsp0_slaver_fsx  <= 1'b1;
    mcbsp0_slaver_mosi <= 1'b0;
    for (int i = 31; i >= 0; i--) begin
      @(negedge mcbsp0_slaver_clkx);
      mcbsp0_slaver_fsx  <= 1'b0;
      mcbsp0_slaver_mosi <= w[i];
    end
  endtask

  task automatic read_word(input logic [bank_aw:0] addr, output logic [31:0] data);
    @(posedge mcbsp0_slaver_clkx);
    read_addr <= addr;
    rd_req    <= 1'b1;
    do @(negedge mcbsp0_slaver_clkx); while (!rd_ack);
    data = send_data;
    @(posedge mcbsp0_slaver_clkx);
    rd_req <= 1'b0;
    do @(negedge mcbsp0_slaver_clkx); while (rd_ack);  // four-phase release
  endtask

  task automatic read_bank(input int b);
    logic [31:0] d;
    for (int i = 0; i < payload_words; i++) begin
      read_word((bank_aw + 1)'(b * (2 ** bank_aw) + i), d);
      check_val("send_data", d, exp_mem[b * (2 ** bank_aw) + i]);
    end
  endtask

  task automatic check_reset();
    check_val("pulse_vec", pulse_vec, '0);
    check_val("start_send", start_send, '0);
    check_val("send_step", send_step, '0);
    check_val("rd_ack", rd_ack, '0);
    check_val("dsp_start_send", dsp_start_send, '0);
    check_val("send_data", send_data, '0);
    check_val("coarse_syn_pos", coarse_syn_pos, '0);
    check_val("fine_syn_pos", fine_syn_pos, '0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    cfg_rst            = 1'b1;
    mcbsp0_slaver_fsx  = 1'b0;
    mcbsp0_slaver_mosi = 1'b0;
    read_addr          = '0;
    rd_req             = 1'b0;
    blocks_done        = 0;
    build_table();
    repeat (4) @(posedge mcbsp0_slaver_clkx);
    cfg_rst <= 1'b0;
    @(negedge mcbsp0_slaver_clkx);
    check_reset();

    for (int k = 0; k < tbl_len; k++) begin
      send_word(tbl[k].word);
      @(posedge mcbsp0_slaver_clkx);  // E, last bit sampled
      @(posedge mcbsp0_slaver_clkx);  // E+1, decoder outputs
      @(negedge mcbsp0_slaver_clkx);
      check_val("pulse_vec", pulse_vec, tbl[k].pulses);
      check_val("start_send", start_send, tbl[k].pulses[11]);
      check_val("send_step", send_step, tbl[k].step);
      check_val("coarse_syn_pos", coarse_syn_pos, tbl[k].cpos);
      check_val("fine_syn_pos", fine_syn_pos, tbl[k].fpos);
      check_val("dsp_start_send", dsp_start_send, tbl[k].started);
      @(negedge mcbsp0_slaver_clkx);
      check_val("pulse_vec", pulse_vec, '0);  // every pulse one cycle wide
      check_val("start_send", start_send, tbl[k].pulses[11]);
      if (tbl[k].pulses[0]) begin
        read_bank(blocks_done);  // block just completed
        blocks_done++;
      end
    end
    read_bank(0);  // first block survives the second

    @(posedge mcbsp0_slaver_clkx);
    cfg_rst <= 1'b1;
    repeat (4) @(posedge mcbsp0_slaver_clkx);
    cfg_rst <= 1'b0;
    @(negedge mcbsp0_slaver_clkx);
    check_reset();

    $display("TEST OK");
    $finish;
  end

  initial begin
    wait (dsp_fpga_link_i.dsp_fpga_link_properties_i.failed === 1'b1);
    $display("an assertion in dsp_fpga_link_properties failed");
    $display("TEST FAILED");
    $fatal(1, "stopped at first assertion failure");
  end

  initial begin
    #(watchdog_cycles * period);
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAILED");
    $fatal(1, "run stopped by watchdog");
  end

endmodule
